// ==== hdl/stream_pipe_pkg.sv ====
package stream_pipe_pkg;

    // Stream field widths
    localparam int DATA_WIDTH = 16;
    localparam int KEEP_WIDTH = 2;

    // Counter widths
    localparam int BEAT_CNT_WIDTH  = 8;
    localparam int FRAME_CNT_WIDTH = 16;

    // Register stages in the pipeline FIFO
    localparam int PIPE_LENGTH = 2;

    // Legal frame length in beats, both ends included
    localparam int MIN_FRAME_BEATS = 2;
    localparam int MAX_FRAME_BEATS = 32;

    typedef logic [DATA_WIDTH-1:0] data_t;
    typedef logic [KEEP_WIDTH-1:0] keep_t;

    // Set on a last beat when the frame is bad
    typedef logic [0:0] user_t;

    // Saturates at all ones
    typedef logic [BEAT_CNT_WIDTH-1:0] beat_cnt_t;

    // Wraps around
    typedef logic [FRAME_CNT_WIDTH-1:0] frame_cnt_t;

endpackage

// ==== hdl/axis_frame_len_check.sv ====
`timescale 1ns/1ps

module axis_frame_len_check (
    input  logic                    clk,
    input  logic                    rst,

    input  stream_pipe_pkg::data_t  s_axis_tdata,
    input  stream_pipe_pkg::keep_t  s_axis_tkeep,
    input  logic                    s_axis_tvalid,
    output logic                    s_axis_tready,
    input  logic                    s_axis_tlast,
    input  stream_pipe_pkg::user_t  s_axis_tuser,

    output stream_pipe_pkg::data_t  m_axis_tdata,
    output stream_pipe_pkg::keep_t  m_axis_tkeep,
    output logic                    m_axis_tvalid,
    input  logic                    m_axis_tready,
    output logic                    m_axis_tlast,
    output stream_pipe_pkg::user_t  m_axis_tuser
);
    import stream_pipe_pkg::*;

    // Beats already accepted in the current frame
    beat_cnt_t beat_cnt;
    // Length of the frame up to and including the current beat
    beat_cnt_t frame_len;
    logic      len_bad;
    logic      xfer;

    assign xfer = s_axis_tvalid && s_axis_tready;

    // Stops at the counter maximum so long frames stay out of range
    assign frame_len = (beat_cnt == '1) ? beat_cnt : beat_cnt + beat_cnt_t'(1);

    assign len_bad = (frame_len < beat_cnt_t'(MIN_FRAME_BEATS))
                  || (frame_len > beat_cnt_t'(MAX_FRAME_BEATS));

    // No storage in this stage, ready comes straight from downstream
    assign s_axis_tready = m_axis_tready;

    assign m_axis_tdata  = s_axis_tdata;
    assign m_axis_tkeep  = s_axis_tkeep;
    assign m_axis_tvalid = s_axis_tvalid;
    assign m_axis_tlast  = s_axis_tlast;

    // Length error only lands on the last beat, other beats keep their flag
    assign m_axis_tuser = s_axis_tuser | user_t'(s_axis_tlast && len_bad);

    always_ff @(posedge clk) begin
        if (rst) begin
            beat_cnt <= '0;
        end else if (xfer) begin
            if (s_axis_tlast) begin
                beat_cnt <= '0;
            end else begin
                beat_cnt <= frame_len;
            end
        end
    end

endmodule

// ==== hdl/axis_pipeline_fifo.sv ====
`timescale 1ns/1ps

module axis_pipeline_fifo #(
    parameter int LENGTH = 2
) (
    input  logic                    clk,
    input  logic                    rst,

    input  stream_pipe_pkg::data_t  s_axis_tdata,
    input  stream_pipe_pkg::keep_t  s_axis_tkeep,
    input  logic                    s_axis_tvalid,
    output logic                    s_axis_tready,
    input  logic                    s_axis_tlast,
    input  stream_pipe_pkg::user_t  s_axis_tuser,

    output stream_pipe_pkg::data_t  m_axis_tdata,
    output stream_pipe_pkg::keep_t  m_axis_tkeep,
    output logic                    m_axis_tvalid,
    input  logic                    m_axis_tready,
    output logic                    m_axis_tlast,
    output stream_pipe_pkg::user_t  m_axis_tuser
);
    import stream_pipe_pkg::*;

    // Deep enough for the beats still in flight once ready drops
    localparam int FIFO_ADDR_WIDTH = (LENGTH < 2) ? 3 : $clog2(LENGTH * 4);
    localparam int FIFO_DEPTH      = 2 ** FIFO_ADDR_WIDTH;

    // Extra top bit tells full from empty
    typedef logic [FIFO_ADDR_WIDTH:0]   ptr_t;
    typedef logic [FIFO_ADDR_WIDTH-1:0] addr_t;

    // Forward pipeline
    data_t pipe_tdata  [LENGTH];
    keep_t pipe_tkeep  [LENGTH];
    logic  pipe_tlast  [LENGTH];
    user_t pipe_tuser  [LENGTH];
    logic  pipe_tvalid [LENGTH];

    // Ready travels the other way, index 0 faces the input
    logic  pipe_tready [LENGTH];

    // Distributed memory FIFO
    data_t fifo_tdata [FIFO_DEPTH];
    keep_t fifo_tkeep [FIFO_DEPTH];
    logic  fifo_tlast [FIFO_DEPTH];
    user_t fifo_tuser [FIFO_DEPTH];

    ptr_t  wr_ptr;
    ptr_t  rd_ptr;
    ptr_t  fifo_count;
    addr_t wr_addr;
    addr_t rd_addr;
    logic  fifo_full;
    logic  fifo_empty;
    logic  half_full;
    logic  fifo_wr;
    logic  fifo_rd;

    // Output register stage
    data_t out_tdata;
    keep_t out_tkeep;
    logic  out_tvalid;
    logic  out_tlast;
    user_t out_tuser;

    assign s_axis_tready = pipe_tready[0];

    always_ff @(posedge clk) begin
        pipe_tdata[0] <= s_axis_tdata;
        pipe_tkeep[0] <= s_axis_tkeep;
        pipe_tlast[0] <= s_axis_tlast;
        pipe_tuser[0] <= s_axis_tuser;
        for (int i = 1; i < LENGTH; i++) begin
            pipe_tdata[i] <= pipe_tdata[i-1];
            pipe_tkeep[i] <= pipe_tkeep[i-1];
            pipe_tlast[i] <= pipe_tlast[i-1];
            pipe_tuser[i] <= pipe_tuser[i-1];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < LENGTH; i++) begin
                pipe_tvalid[i] <= 1'b0;
                pipe_tready[i] <= 1'b0;
            end
        end else begin
            // Only accepted beats enter as valid
            pipe_tvalid[0]        <= s_axis_tvalid && s_axis_tready;
            pipe_tready[LENGTH-1] <= !half_full;
            for (int i = 1; i < LENGTH; i++) begin
                pipe_tvalid[i]   <= pipe_tvalid[i-1];
                pipe_tready[i-1] <= pipe_tready[i];
            end
        end
    end

    assign fifo_count = wr_ptr - rd_ptr;
    assign fifo_full  = (fifo_count == ptr_t'(FIFO_DEPTH));
    assign fifo_empty = (wr_ptr == rd_ptr);
    assign half_full  = (fifo_count >= ptr_t'(FIFO_DEPTH / 2));
    assign wr_addr    = wr_ptr[FIFO_ADDR_WIDTH-1:0];
    assign rd_addr    = rd_ptr[FIFO_ADDR_WIDTH-1:0];

    assign fifo_wr = pipe_tvalid[LENGTH-1] && !fifo_full;

    // Refill the output register when it is empty or being drained
    assign fifo_rd = !fifo_empty && (!out_tvalid || m_axis_tready);

    always_ff @(posedge clk) begin
        if (fifo_wr) begin
            fifo_tdata[wr_addr] <= pipe_tdata[LENGTH-1];
            fifo_tkeep[wr_addr] <= pipe_tkeep[LENGTH-1];
            fifo_tlast[wr_addr] <= pipe_tlast[LENGTH-1];
            fifo_tuser[wr_addr] <= pipe_tuser[LENGTH-1];
        end
    end

    always_ff @(posedge clk) begin
        if (fifo_rd) begin
            out_tdata <= fifo_tdata[rd_addr];
            out_tkeep <= fifo_tkeep[rd_addr];
            out_tlast <= fifo_tlast[rd_addr];
            out_tuser <= fifo_tuser[rd_addr];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            out_tvalid <= 1'b0;
        end else begin
            if (fifo_wr) begin
                wr_ptr <= wr_ptr + ptr_t'(1);
            end

            if (fifo_rd) begin
                rd_ptr     <= rd_ptr + ptr_t'(1);
                out_tvalid <= 1'b1;
            end else if (m_axis_tready) begin
                out_tvalid <= 1'b0;
            end
        end
    end

    assign m_axis_tdata  = out_tdata;
    assign m_axis_tkeep  = out_tkeep;
    assign m_axis_tvalid = out_tvalid;
    assign m_axis_tlast  = out_tlast;
    assign m_axis_tuser  = out_tuser;

endmodule

// ==== hdl/axis_frame_stats.sv ====
`timescale 1ns/1ps

module axis_frame_stats (
    input  logic                        clk,
    input  logic                        rst,

    input  stream_pipe_pkg::data_t      s_axis_tdata,
    input  stream_pipe_pkg::keep_t      s_axis_tkeep,
    input  logic                        s_axis_tvalid,
    output logic                        s_axis_tready,
    input  logic                        s_axis_tlast,
    input  stream_pipe_pkg::user_t      s_axis_tuser,

    output stream_pipe_pkg::data_t      m_axis_tdata,
    output stream_pipe_pkg::keep_t      m_axis_tkeep,
    output logic                        m_axis_tvalid,
    input  logic                        m_axis_tready,
    output logic                        m_axis_tlast,
    output stream_pipe_pkg::user_t      m_axis_tuser,

    output stream_pipe_pkg::frame_cnt_t good_frames,
    output stream_pipe_pkg::frame_cnt_t bad_frames
);
    import stream_pipe_pkg::*;

    frame_cnt_t good_cnt;
    frame_cnt_t bad_cnt;
    logic       last_xfer;

    // Stream goes through untouched
    assign s_axis_tready = m_axis_tready;
    assign m_axis_tdata  = s_axis_tdata;
    assign m_axis_tkeep  = s_axis_tkeep;
    assign m_axis_tvalid = s_axis_tvalid;
    assign m_axis_tlast  = s_axis_tlast;
    assign m_axis_tuser  = s_axis_tuser;

    // A frame completes when its last beat is taken downstream
    assign last_xfer = s_axis_tvalid && m_axis_tready && s_axis_tlast;

    always_ff @(posedge clk) begin
        if (rst) begin
            good_cnt <= '0;
            bad_cnt  <= '0;
        end else if (last_xfer) begin
            if (s_axis_tuser == user_t'(0)) begin
                good_cnt <= good_cnt + frame_cnt_t'(1);
            end else begin
                bad_cnt <= bad_cnt + frame_cnt_t'(1);
            end
        end
    end

    assign good_frames = good_cnt;
    assign bad_frames  = bad_cnt;

endmodule

// ==== hdl/stream_pipe_top.sv ====
`timescale 1ns/1ps

module stream_pipe_top (
    input  logic                        clk,
    input  logic                        rst,

    input  stream_pipe_pkg::data_t      s_axis_tdata,
    input  stream_pipe_pkg::keep_t      s_axis_tkeep,
    input  logic                        s_axis_tvalid,
    output logic                        s_axis_tready,
    input  logic                        s_axis_tlast,
    input  stream_pipe_pkg::user_t      s_axis_tuser,

    output stream_pipe_pkg::data_t      m_axis_tdata,
    output stream_pipe_pkg::keep_t      m_axis_tkeep,
    output logic                        m_axis_tvalid,
    input  logic                        m_axis_tready,
    output logic                        m_axis_tlast,
    output stream_pipe_pkg::user_t      m_axis_tuser,

    output stream_pipe_pkg::frame_cnt_t good_frames,
    output stream_pipe_pkg::frame_cnt_t bad_frames
);
    import stream_pipe_pkg::*;

    // Length checker to pipeline FIFO
    data_t chk_tdata;
    keep_t chk_tkeep;
    logic  chk_tvalid;
    logic  chk_tready;
    logic  chk_tlast;
    user_t chk_tuser;

    // Pipeline FIFO to statistics
    data_t fifo_tdata;
    keep_t fifo_tkeep;
    logic  fifo_tvalid;
    logic  fifo_tready;
    logic  fifo_tlast;
    user_t fifo_tuser;

    axis_frame_len_check u_len_check (
        .clk           (clk),
        .rst           (rst),
        .s_axis_tdata  (s_axis_tdata),
        .s_axis_tkeep  (s_axis_tkeep),
        .s_axis_tvalid (s_axis_tvalid),
        .s_axis_tready (s_axis_tready),
        .s_axis_tlast  (s_axis_tlast),
        .s_axis_tuser  (s_axis_tuser),
        .m_axis_tdata  (chk_tdata),
        .m_axis_tkeep  (chk_tkeep),
        .m_axis_tvalid (chk_tvalid),
        .m_axis_tready (chk_tready),
        .m_axis_tlast  (chk_tlast),
        .m_axis_tuser  (chk_tuser)
    );

    axis_pipeline_fifo #(
        .LENGTH (PIPE_LENGTH)
    ) u_pipe_fifo (
        .clk           (clk),
        .rst           (rst),
        .s_axis_tdata  (chk_tdata),
        .s_axis_tkeep  (chk_tkeep),
        .s_axis_tvalid (chk_tvalid),
        .s_axis_tready (chk_tready),
        .s_axis_tlast  (chk_tlast),
        .s_axis_tuser  (chk_tuser),
        .m_axis_tdata  (fifo_tdata),
        .m_axis_tkeep  (fifo_tkeep),
        .m_axis_tvalid (fifo_tvalid),
        .m_axis_tready (fifo_tready),
        .m_axis_tlast  (fifo_tlast),
        .m_axis_tuser  (fifo_tuser)
    );

    axis_frame_stats u_stats (
        .clk           (clk),
        .rst           (rst),
        .s_axis_tdata  (fifo_tdata),
        .s_axis_tkeep  (fifo_tkeep),
        .s_axis_tvalid (fifo_tvalid),
        .s_axis_tready (fifo_tready),
        .s_axis_tlast  (fifo_tlast),
        .s_axis_tuser  (fifo_tuser),
        .m_axis_tdata  (m_axis_tdata),
        .m_axis_tkeep  (m_axis_tkeep),
        .m_axis_tvalid (m_axis_tvalid),
        .m_axis_tready (m_axis_tready),
        .m_axis_tlast  (m_axis_tlast),
        .m_axis_tuser  (m_axis_tuser),
        .good_frames   (good_frames),
        .bad_frames    (bad_frames)
    );

endmodule

// ==== bench/stream_pipe_chk.sv ====
`timescale 1ns/1ps

module stream_pipe_chk (
    input logic                   clk,
    input logic                   rst,
    input logic                   s_axis_tready,
    input stream_pipe_pkg::data_t m_axis_tdata,
    input stream_pipe_pkg::keep_t m_axis_tkeep,
    input logic                   m_axis_tvalid,
    input logic                   m_axis_tready,
    input logic                   m_axis_tlast,
    input stream_pipe_pkg::user_t m_axis_tuser
);

    // A stalled output beat must hold until it is taken
    property stalled_beat_holds;
        @(posedge clk) disable iff (rst)
        (m_axis_tvalid && !m_axis_tready) |=>
            (m_axis_tvalid && $stable(m_axis_tdata) && $stable(m_axis_tkeep)
             && $stable(m_axis_tlast) && $stable(m_axis_tuser));
    endproperty

    stalled_beat_holds_a: assert property (stalled_beat_holds)
        else $error("output beat changed or dropped while stalled");

    valid_low_in_reset_a: assert property (@(posedge clk) rst |=> !m_axis_tvalid)
        else $error("output tvalid high during reset");

    // Delayed ready registers are still empty right after reset
    ready_low_after_reset_a: assert property (@(posedge clk) $fell(rst) |-> !s_axis_tready)
        else $error("input tready high on the first cycle after reset");

endmodule

bind stream_pipe_top stream_pipe_chk chk (
    .clk           (clk),
    .rst           (rst),
    .s_axis_tready (s_axis_tready),
    .m_axis_tdata  (m_axis_tdata),
    .m_axis_tkeep  (m_axis_tkeep),
    .m_axis_tvalid (m_axis_tvalid),
    .m_axis_tready (m_axis_tready),
    .m_axis_tlast  (m_axis_tlast),
    .m_axis_tuser  (m_axis_tuser)
);

// ==== bench/stream_pipe_tb.sv ====
`timescale 1ns/1ps

module stream_pipe_tb;
    import stream_pipe_pkg::*;

    localparam int          NUM_FRAMES    = 300;
    localparam int          READY_TIMEOUT = 500;
    localparam int          DRAIN_TIMEOUT = 2000;
    localparam logic [31:0] SEED          = 32'ha23b_d758;

    logic       clk;
    logic       rst;
    data_t      s_axis_tdata;
    keep_t      s_axis_tkeep;
    logic       s_axis_tvalid;
    logic       s_axis_tready;
    logic       s_axis_tlast;
    user_t      s_axis_tuser;
    data_t      m_axis_tdata;
    keep_t      m_axis_tkeep;
    logic       m_axis_tvalid;
    logic       m_axis_tready;
    logic       m_axis_tlast;
    user_t      m_axis_tuser;
    frame_cnt_t good_frames;
    frame_cnt_t bad_frames;

    // Expected beats in order of acceptance
    data_t exp_data_q[$];
    keep_t exp_keep_q[$];
    logic  exp_last_q[$];
    user_t exp_user_q[$];

    int         in_len = 0;
    user_t      in_flag;
    frame_cnt_t model_good = '0;
    frame_cnt_t model_bad  = '0;
    frame_cnt_t out_good   = '0;
    frame_cnt_t out_bad    = '0;

    stream_pipe_top dut (
        .clk           (clk),
        .rst           (rst),
        .s_axis_tdata  (s_axis_tdata),
        .s_axis_tkeep  (s_axis_tkeep),
        .s_axis_tvalid (s_axis_tvalid),
        .s_axis_tready (s_axis_tready),
        .s_axis_tlast  (s_axis_tlast),
        .s_axis_tuser  (s_axis_tuser),
        .m_axis_tdata  (m_axis_tdata),
        .m_axis_tkeep  (m_axis_tkeep),
        .m_axis_tvalid (m_axis_tvalid),
        .m_axis_tready (m_axis_tready),
        .m_axis_tlast  (m_axis_tlast),
        .m_axis_tuser  (m_axis_tuser),
        .good_frames   (good_frames),
        .bad_frames    (bad_frames)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic fail_run(string reason);
        $display("%s", reason);
        $display("TESTBENCH FAILED");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic check_data(string name, data_t got, data_t want);
        if (got !== want)
            fail_run($sformatf("CHECK FAILED %s got 0x%h expected 0x%h", name, got, want));
    endtask

    task automatic check_keep(string name, keep_t got, keep_t want);
        if (got !== want)
            fail_run($sformatf("CHECK FAILED %s got 0x%h expected 0x%h", name, got, want));
    endtask

    task automatic check_flag(string name, user_t got, user_t want);
        if (got !== want)
            fail_run($sformatf("CHECK FAILED %s got 0x%h expected 0x%h", name, got, want));
    endtask

    task automatic check_count(string name, frame_cnt_t got, frame_cnt_t want);
        if (got !== want)
            fail_run($sformatf("CHECK FAILED %s got 0x%h expected 0x%h", name, got, want));
    endtask

    // First frames hit the range edges, the rest are random
    function automatic int pick_length(int idx);
        case (idx)
            0:       return 1;
            1:       return MAX_FRAME_BEATS + 1;
            2:       return MIN_FRAME_BEATS;
            3:       return MAX_FRAME_BEATS;
            4:       return 40;
            default: return $urandom_range(40, 1);
        endcase
    endfunction

    // Output stalls at random, slower than the input on average
    initial begin
        m_axis_tready = 1'b0;
        forever begin
            @(negedge clk);
            m_axis_tready = (($urandom % 10) < 6);
        end
    end

    // Reference model, sampled on the edge where transfers happen
    always @(posedge clk) begin
        if (!rst) begin
            check_count("good_frames", good_frames, out_good);
            check_count("bad_frames", bad_frames, out_bad);

            if (s_axis_tvalid && s_axis_tready) begin
                in_len++;
                in_flag = s_axis_tuser;
                if (s_axis_tlast) begin
                    if (in_len < MIN_FRAME_BEATS || in_len > MAX_FRAME_BEATS)
                        in_flag = 1'b1;
                    if (in_flag == 1'b1)
                        model_bad = model_bad + frame_cnt_t'(1);
                    else
                        model_good = model_good + frame_cnt_t'(1);
                    in_len = 0;
                end
                exp_data_q.push_back(s_axis_tdata);
                exp_keep_q.push_back(s_axis_tkeep);
                exp_last_q.push_back(s_axis_tlast);
                exp_user_q.push_back(in_flag);
            end

            if (m_axis_tvalid && m_axis_tready) begin
                if (exp_data_q.size() == 0) begin
                    fail_run("output delivered a beat that was never sent");
                end else begin
                    check_data("m_axis_tdata", m_axis_tdata, exp_data_q[0]);
                    check_keep("m_axis_tkeep", m_axis_tkeep, exp_keep_q[0]);
                    check_flag("m_axis_tlast", user_t'(m_axis_tlast), user_t'(exp_last_q[0]));
                    check_flag("m_axis_tuser", m_axis_tuser, exp_user_q[0]);
                    if (exp_last_q[0]) begin
                        if (exp_user_q[0] == 1'b1)
                            out_bad = out_bad + frame_cnt_t'(1);
                        else
                            out_good = out_good + frame_cnt_t'(1);
                    end
                    void'(exp_data_q.pop_front());
                    void'(exp_keep_q.pop_front());
                    void'(exp_last_q.pop_front());
                    void'(exp_user_q.pop_front());
                end
            end
        end
    end

    // Called on a falling edge, returns on the falling edge after the transfer
    task automatic send_beat(data_t data, keep_t keep, logic last, user_t user);
        int waited;
        waited = 0;
        s_axis_tdata  = data;
        s_axis_tkeep  = keep;
        s_axis_tlast  = last;
        s_axis_tuser  = user;
        s_axis_tvalid = 1'b1;
        // tready only moves on rising edges, so it holds until the next one
        while (!s_axis_tready) begin
            if (waited >= READY_TIMEOUT) begin
                fail_run("input tready stayed low for too long");
            end else begin
                waited++;
                @(negedge clk);
            end
        end
        @(negedge clk);
    endtask

    task automatic insert_gap();
        if (($urandom % 5) == 0) begin
            s_axis_tvalid = 1'b0;
            repeat (1 + ($urandom % 3)) @(negedge clk);
        end
    endtask

    task automatic send_frame(int len, bit allow_gap);
        logic  last;
        user_t user;
        for (int i = 0; i < len; i++) begin
            if (allow_gap || i > 0)
                insert_gap();
            last = (i == len - 1);
            user = user_t'(last && (($urandom % 12) == 0));
            send_beat(data_t'($urandom), keep_t'($urandom), last, user);
        end
    endtask

    task automatic wait_drain();
        int waited;
        waited = 0;
        while (exp_data_q.size() != 0 || m_axis_tvalid) begin
            if (waited >= DRAIN_TIMEOUT) begin
                fail_run("pipeline did not empty within 2000 cycles");
            end else begin
                waited++;
                @(negedge clk);
            end
        end
    endtask

    initial begin
        void'($urandom(SEED));
        rst           = 1'b1;
        s_axis_tdata  = '0;
        s_axis_tkeep  = '0;
        s_axis_tvalid = 1'b0;
        s_axis_tlast  = 1'b0;
        s_axis_tuser  = '0;

        for (int i = 0; i < 4; i++) begin
            @(negedge clk);
            check_flag("m_axis_tvalid", user_t'(m_axis_tvalid), 1'b0);
            check_flag("s_axis_tready", user_t'(s_axis_tready), 1'b0);
            check_count("good_frames", good_frames, '0);
            check_count("bad_frames", bad_frames, '0);
        end
        rst = 1'b0;

        // First beat is offered right away, before tready rises
        for (int f = 0; f < NUM_FRAMES; f++)
            send_frame(pick_length(f), f > 0);
        s_axis_tvalid = 1'b0;
        s_axis_tlast  = 1'b0;

        wait_drain();
        @(negedge clk);
        check_count("good_frames", good_frames, model_good);
        check_count("bad_frames", bad_frames, model_bad);

        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

// ==== stream_pipe.f ====
hdl/stream_pipe_pkg.sv
hdl/axis_frame_len_check.sv
hdl/axis_pipeline_fifo.sv
hdl/axis_frame_stats.sv
hdl/stream_pipe_top.sv
bench/stream_pipe_chk.sv
bench/stream_pipe_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the stream_pipe testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir

verilator --binary --timing --assert \
    --timescale 1ns/1ps \
    --top-module stream_pipe_tb \
    --Mdir "$BUILD_DIR" \
    -f stream_pipe.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

OUTPUT=$("./$BUILD_DIR/Vstream_pipe_tb" 2>&1)
STATUS=$?
echo "$OUTPUT"
if [ $STATUS -ne 0 ]; then
    echo "Simulation exited with status $STATUS"
    exit 1
fi

if echo "$OUTPUT" | grep -q "^TESTBENCH PASSED$"; then
    exit 0
fi
echo "Pass message not found in simulation output"
exit 1
